// File: rv_decoder.f
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/pipe_stage_reg.sv
src/imm_gen_stage.sv
src/ctrl_decode_stage.sv
src/rv_decoder.sv
verification/tb_rv_decoder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the decoder testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_rv_decoder -f rv_decoder.f \
    --Mdir obj_dir -o sim_rv_decoder

./obj_dir/sim_rv_decoder > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1

// File: verification/decode_stimulus.txt
// inst pc_wr_en pc_wr_sel rd_wr_en rd_wr_sel rd_wr_addr rs1 rs2 alu_a alu_b
// alu_comp alu_op_0 alu_op_1 dram_wr_en dram_wr_sel dram_rd_sel imm
fff10093 1 0 1 0 01 02 1f 1 2 0 0 0 0 0 0 ffffffff
40525193 1 0 1 0 03 04 05 1 2 5 1 5 0 5 5 00000405
7ff30293 1 0 1 0 05 06 1f 1 2 0 0 0 0 0 0 000007ff
800003b7 1 0 1 0 07 00 00 0 2 0 0 0 0 0 0 80000000
12345417 1 0 1 0 08 08 03 2 2 5 0 0 0 5 5 12345000
00b504b3 1 0 1 0 09 0a 0b 1 1 0 0 0 0 0 0 00000000
40e68633 1 0 1 0 0c 0d 0e 1 1 0 1 0 0 0 0 00000000
411857b3 1 0 1 0 0f 10 11 1 1 5 1 5 0 5 5 00000000
011857b3 1 0 1 0 0f 10 11 1 1 5 0 5 0 5 5 00000000
ffdff0ef 1 1 1 2 01 1f 1d 2 2 7 0 0 0 7 7 fffffffc
0010006f 1 1 1 2 00 00 01 2 2 0 0 0 0 0 0 00000800
008280e7 1 2 1 2 01 05 08 1 2 0 0 0 0 0 0 00000008
fe208ce3 1 3 0 0 19 01 02 2 2 0 0 0 0 0 0 fffffff8
00419863 1 3 0 0 10 03 04 2 2 1 0 0 0 1 1 00000010
ffc3a303 0 0 1 1 06 07 1c 1 2 2 0 0 0 2 2 fffffffc
fe84aa23 1 0 0 0 14 09 08 1 2 2 0 0 1 2 2 fffffff4
00a582a3 1 0 0 0 05 0b 0a 1 2 0 0 0 1 0 0 00000005
00b504b1 1 0 0 0 09 0a 0b 0 0 0 0 0 0 0 0 00000000
0ff0000f 1 0 0 0 00 00 1f 0 0 0 0 0 0 0 0 00000000

// File: verification/tb_rv_decoder.sv
/* Testbench for the RV32I decoder: reset state, file-driven decode checks,
   latency at full rate and ordering under random back-pressure */

module tb_rv_decoder;

localparam int CLK_PERIOD    = 100;
localparam int SETTLE        = 10;
localparam int RESET_CYCLES  = 4;
localparam int NUM_VECTORS   = 19;
localparam int FIELD_COUNT   = 16;
localparam int ROW_WORDS     = FIELD_COUNT + 1;    // Instruction, then the expected fields
localparam int WATCHDOG_TIME = (NUM_VECTORS * 20 + 50) * CLK_PERIOD;
localparam logic [31:0] LCG_SEED = 32'd14875;

logic        clk_i;
logic        rst_n_i;
logic        inst_valid_i;
logic        inst_ready_o;
logic [31:0] inst_data_i;
logic        dec_ready_i;
logic        dec_valid_o;
logic        pc_wr_en_o;
logic [1:0]  pc_wr_sel_o;
logic        rd_wr_en_o;
logic [1:0]  rd_wr_sel_o;
logic [4:0]  rd_wr_addr_o;
logic [4:0]  rs1_rd_addr_o;
logic [4:0]  rs2_rd_addr_o;
logic [1:0]  alu_a_sel_o;
logic [1:0]  alu_b_sel_o;
logic [2:0]  alu_comp_sel_o;
logic        alu_op_0_sel_o;
logic [2:0]  alu_op_1_sel_o;
logic        dram_wr_en_o;
logic [2:0]  dram_wr_sel_o;
logic [2:0]  dram_rd_sel_o;
logic [31:0] imm_rd_data_o;

logic [31:0] stim_mem [NUM_VECTORS * ROW_WORDS];
logic [31:0] cur_word [FIELD_COUNT];
logic [31:0] held_word [FIELD_COUNT];
string field_names [FIELD_COUNT] = '{
    "pc_wr_en", "pc_wr_sel", "rd_wr_en", "rd_wr_sel", "rd_wr_addr", "rs1_rd_addr",
    "rs2_rd_addr", "alu_a_sel", "alu_b_sel", "alu_comp_sel", "alu_op_0_sel",
    "alu_op_1_sel", "dram_wr_en", "dram_wr_sel", "dram_rd_sel", "imm_rd_data"
};

int exp_idx_q [$];      // Vector index of every word inside the DUT, oldest first
int exp_cycle_q [$];
logic [31:0] lcg_state;
int error_count;
int tests_passed;
int tests_failed;
bit saw_full_stall;

rv_decoder u_dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .inst_valid_i   (inst_valid_i),
    .inst_ready_o   (inst_ready_o),
    .inst_data_i    (inst_data_i),
    .dec_ready_i    (dec_ready_i),
    .dec_valid_o    (dec_valid_o),
    .pc_wr_en_o     (pc_wr_en_o),
    .pc_wr_sel_o    (pc_wr_sel_o),
    .rd_wr_en_o     (rd_wr_en_o),
    .rd_wr_sel_o    (rd_wr_sel_o),
    .rd_wr_addr_o   (rd_wr_addr_o),
    .rs1_rd_addr_o  (rs1_rd_addr_o),
    .rs2_rd_addr_o  (rs2_rd_addr_o),
    .alu_a_sel_o    (alu_a_sel_o),
    .alu_b_sel_o    (alu_b_sel_o),
    .alu_comp_sel_o (alu_comp_sel_o),
    .alu_op_0_sel_o (alu_op_0_sel_o),
    .alu_op_1_sel_o (alu_op_1_sel_o),
    .dram_wr_en_o   (dram_wr_en_o),
    .dram_wr_sel_o  (dram_wr_sel_o),
    .dram_rd_sel_o  (dram_rd_sel_o),
    .imm_rd_data_o  (imm_rd_data_o)
);

initial begin
    clk_i = 1'b0;
    forever begin
        #(CLK_PERIOD / 2);
        clk_i = ~clk_i;
    end
end

initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the decoder stopped delivering words before the tests finished");
    $display("TEST FAIL");
    $finish;
end

// -------------------------------------------------------------------------
// Helpers
// -------------------------------------------------------------------------
function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

task automatic report_mismatch(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    error_count++;
endtask

task automatic report_problem(input string msg);
    $display("%s", msg);
    error_count++;
endtask

task automatic capture_outputs();
    cur_word[0]  = 32'(pc_wr_en_o);
    cur_word[1]  = 32'(pc_wr_sel_o);
    cur_word[2]  = 32'(rd_wr_en_o);
    cur_word[3]  = 32'(rd_wr_sel_o);
    cur_word[4]  = 32'(rd_wr_addr_o);
    cur_word[5]  = 32'(rs1_rd_addr_o);
    cur_word[6]  = 32'(rs2_rd_addr_o);
    cur_word[7]  = 32'(alu_a_sel_o);
    cur_word[8]  = 32'(alu_b_sel_o);
    cur_word[9]  = 32'(alu_comp_sel_o);
    cur_word[10] = 32'(alu_op_0_sel_o);
    cur_word[11] = 32'(alu_op_1_sel_o);
    cur_word[12] = 32'(dram_wr_en_o);
    cur_word[13] = 32'(dram_wr_sel_o);
    cur_word[14] = 32'(dram_rd_sel_o);
    cur_word[15] = imm_rd_data_o;
endtask

task automatic check_vector(input int idx);
    int base;
    base = idx * ROW_WORDS;
    for (int f = 0; f < FIELD_COUNT; f++) begin
        if (cur_word[f] !== stim_mem[base + 1 + f]) begin
            report_mismatch($sformatf("vector %0d (%h) field %s expected %h got %h",
                idx, stim_mem[base], field_names[f], stim_mem[base + 1 + f], cur_word[f]));
        end
    end
endtask

task automatic check_idle_outputs(input string when);
    if (dec_valid_o !== 1'b0) begin
        report_mismatch($sformatf("dec_valid_o high %s", when));
    end
    if (pc_wr_en_o !== 1'b0 || rd_wr_en_o !== 1'b0 || dram_wr_en_o !== 1'b0) begin
        report_mismatch($sformatf("an enable is high %s", when));
    end
    if (imm_rd_data_o !== 32'd0) begin
        report_mismatch($sformatf("imm_rd_data is %h %s", imm_rd_data_o, when));
    end
endtask

task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
        tests_passed++;
        $display("Test %s: passed", name);
    end else begin
        tests_failed++;
        $display("Test %s: failed with %0d errors", name, error_count - errors_before);
    end
endtask

// -------------------------------------------------------------------------
// Stream all vectors; random mode adds input gaps and output stalls
// -------------------------------------------------------------------------
task automatic run_stream(input bit use_random);
    int next_vec;
    int cycle;
    int idx;
    int in_cycle;
    bit in_fire;
    bit was_stalled;
    logic expected_ready;
    logic [31:0] rnd;

    next_vec    = 0;
    cycle       = 0;
    in_fire     = 1'b0;
    was_stalled = 1'b0;
    while (next_vec < NUM_VECTORS || exp_idx_q.size() != 0) begin
        @(negedge clk_i);
        rnd = use_random ? next_random() : 32'hffff_ffff;    // All ones means no gap, no stall
        if (!inst_valid_i || in_fire) begin
            if (next_vec < NUM_VECTORS && rnd[25:24] != 2'b00) begin
                inst_valid_i = 1'b1;
                inst_data_i  = stim_mem[next_vec * ROW_WORDS];
            end else begin
                inst_valid_i = 1'b0;
            end
        end
        dec_ready_i = rnd[28];
        #(SETTLE);
        capture_outputs();

        if (was_stalled) begin
            if (dec_valid_o !== 1'b1) begin
                report_mismatch("dec_valid_o dropped while the output was stalled");
            end
            for (int f = 0; f < FIELD_COUNT; f++) begin
                if (cur_word[f] !== held_word[f]) begin
                    report_mismatch($sformatf("field %s changed while stalled", field_names[f]));
                end
            end
        end

        // Both stages full and the consumer stalled is the only case that blocks input
        expected_ready = !(exp_idx_q.size() == 2 && !dec_ready_i);
        if (inst_ready_o !== expected_ready) begin
            report_mismatch($sformatf("inst_ready_o is %b with %0d words held, dec_ready_i %b",
                inst_ready_o, exp_idx_q.size(), dec_ready_i));
        end
        if (exp_idx_q.size() == 2 && !dec_ready_i) begin
            saw_full_stall = 1'b1;
        end

        if (dec_valid_o === 1'b1) begin
            if (exp_idx_q.size() == 0) begin
                report_mismatch("dec_valid_o high with no word outstanding");
            end else if (dec_ready_i) begin
                idx      = exp_idx_q.pop_front();
                in_cycle = exp_cycle_q.pop_front();
                check_vector(idx);
                if (!use_random && cycle - in_cycle != 2) begin
                    report_mismatch($sformatf("vector %0d came out %0d cycles after acceptance",
                        idx, cycle - in_cycle));
                end
            end
        end

        was_stalled = (dec_valid_o === 1'b1) && !dec_ready_i;
        held_word   = cur_word;
        in_fire     = inst_valid_i && inst_ready_o;
        if (in_fire) begin
            exp_idx_q.push_back(next_vec);
            exp_cycle_q.push_back(cycle);
            next_vec++;
        end
        cycle++;
    end
    if (!use_random && cycle != NUM_VECTORS + 2) begin
        report_mismatch($sformatf("full-rate stream took %0d cycles for %0d words",
            cycle, NUM_VECTORS));
    end
endtask

// -------------------------------------------------------------------------
// Test sequence
// -------------------------------------------------------------------------
initial begin
    int errors_before;

    rst_n_i        = 1'b0;
    inst_valid_i   = 1'b0;
    inst_data_i    = 32'd0;
    dec_ready_i    = 1'b0;
    lcg_state      = LCG_SEED;
    error_count    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    saw_full_stall = 1'b0;
    $readmemh("verification/decode_stimulus.txt", stim_mem);

    errors_before = error_count;
    repeat (RESET_CYCLES - 1) begin
        @(negedge clk_i);
        #(SETTLE);
        check_idle_outputs("during reset");
    end
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #(SETTLE);
    check_idle_outputs("at reset release");
    @(negedge clk_i);
    #(SETTLE);
    check_idle_outputs("after reset");
    finish_test("reset state", errors_before);

    errors_before = error_count;
    run_stream(1'b0);
    finish_test("decode and latency at full rate", errors_before);

    errors_before = error_count;
    run_stream(1'b1);
    if (!saw_full_stall) begin
        report_problem("Back-pressure never filled both stages, so the ready drop went unchecked");
    end
    finish_test("random back-pressure", errors_before);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (error_count == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule

// File: src/rv_decoder.sv
/* Top of the two-stage RV32I decoder: immediate stage, then control stage */

module rv_decoder (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,

    input  logic                                   inst_valid_i,
    output logic                                   inst_ready_o,
    input  logic [rv_isa_pkg::XLEN-1:0]            inst_data_i,

    input  logic                                   dec_ready_i,
    output logic                                   dec_valid_o,

    output logic                                   pc_wr_en_o,
    output logic [1:0]                             pc_wr_sel_o,

    output logic                                   rd_wr_en_o,
    output logic [1:0]                             rd_wr_sel_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]      rd_wr_addr_o,

    output logic [rv_isa_pkg::REG_ADDR_W-1:0]      rs1_rd_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]      rs2_rd_addr_o,

    output logic [1:0]                             alu_a_sel_o,
    output logic [1:0]                             alu_b_sel_o,
    output logic [rv_ctrl_pkg::FUNCT3_W-1:0]       alu_comp_sel_o,
    output logic                                   alu_op_0_sel_o,
    output logic [rv_ctrl_pkg::FUNCT3_W-1:0]       alu_op_1_sel_o,

    output logic                                   dram_wr_en_o,
    output logic [rv_ctrl_pkg::FUNCT3_W-1:0]       dram_wr_sel_o,
    output logic [rv_ctrl_pkg::FUNCT3_W-1:0]       dram_rd_sel_o,

    output logic [rv_isa_pkg::XLEN-1:0]            imm_rd_data_o
);

logic                    s1_valid;
logic                    s1_ready;
rv_ctrl_pkg::imm_stage_t s1_payload;

imm_gen_stage u_imm_gen_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .inst_data_i  (inst_data_i),
    .s1_valid_o   (s1_valid),
    .s1_ready_i   (s1_ready),
    .s1_data_o    (s1_payload)
);

ctrl_decode_stage u_ctrl_decode_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .s1_valid_i     (s1_valid),
    .s1_ready_o     (s1_ready),
    .s1_data_i      (s1_payload),
    .dec_valid_o    (dec_valid_o),
    .dec_ready_i    (dec_ready_i),
    .pc_wr_en_o     (pc_wr_en_o),
    .pc_wr_sel_o    (pc_wr_sel_o),
    .rd_wr_en_o     (rd_wr_en_o),
    .rd_wr_sel_o    (rd_wr_sel_o),
    .rd_wr_addr_o   (rd_wr_addr_o),
    .rs1_rd_addr_o  (rs1_rd_addr_o),
    .rs2_rd_addr_o  (rs2_rd_addr_o),
    .alu_a_sel_o    (alu_a_sel_o),
    .alu_b_sel_o    (alu_b_sel_o),
    .alu_comp_sel_o (alu_comp_sel_o),
    .alu_op_0_sel_o (alu_op_0_sel_o),
    .alu_op_1_sel_o (alu_op_1_sel_o),
    .dram_wr_en_o   (dram_wr_en_o),
    .dram_wr_sel_o  (dram_wr_sel_o),
    .dram_rd_sel_o  (dram_rd_sel_o),
    .imm_rd_data_o  (imm_rd_data_o)
);

endmodule

// File: src/ctrl_decode_stage.sv
/* Stage 2: control-word decode from the opcode class and funct fields,
   followed by the output register */

module ctrl_decode_stage (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,

    input  logic                                   s1_valid_i,
    output logic                                   s1_ready_o,
    input  rv_ctrl_pkg::imm_stage_t                s1_data_i,

    output logic                                   dec_valid_o,
    input  logic                                   dec_ready_i,

    output logic                                   pc_wr_en_o,
    output logic [1:0]                             pc_wr_sel_o,

    output logic                                   rd_wr_en_o,
    output logic [1:0]                             rd_wr_sel_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]      rd_wr_addr_o,

    output logic [rv_isa_pkg::REG_ADDR_W-1:0]      rs1_rd_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]      rs2_rd_addr_o,

    output logic [1:0]                             alu_a_sel_o,
    output logic [1:0]                             alu_b_sel_o,
    output logic [rv_ctrl_pkg::FUNCT3_W-1:0]       alu_comp_sel_o,
    output logic                                   alu_op_0_sel_o,
    output logic [rv_ctrl_pkg::FUNCT3_W-1:0]       alu_op_1_sel_o,

    output logic                                   dram_wr_en_o,
    output logic [rv_ctrl_pkg::FUNCT3_W-1:0]       dram_wr_sel_o,
    output logic [rv_ctrl_pkg::FUNCT3_W-1:0]       dram_rd_sel_o,

    output logic [rv_isa_pkg::XLEN-1:0]            imm_rd_data_o
);

rv_ctrl_pkg::ctrl_word_t ctrl_next;
rv_ctrl_pkg::ctrl_word_t ctrl_q;

// ----------------------------------------------------------------------------
// Control table, starting from the no-operation word
// ----------------------------------------------------------------------------
always_comb begin
    ctrl_next.pc_wr_en     = 1'b1;
    ctrl_next.pc_wr_sel    = rv_ctrl_pkg::PC_WR_NEXT;
    ctrl_next.rd_wr_en     = 1'b1;
    ctrl_next.rd_wr_sel    = rv_ctrl_pkg::RD_WR_ALU;
    ctrl_next.alu_a_sel    = rv_ctrl_pkg::ALU_A_RS1;
    ctrl_next.alu_b_sel    = rv_ctrl_pkg::ALU_B_IMM;
    ctrl_next.alu_op_0_sel = rv_ctrl_pkg::ALU_OP_0_ADD_SRL;
    ctrl_next.alu_op_1_sel = rv_ctrl_pkg::ALU_OP_1_ADD;
    ctrl_next.dram_wr_en   = 1'b0;

    case (s1_data_i.op_class)
        rv_isa_pkg::CLASS_OP_IMM: begin
            // SRAI only; ADDI with bit 30 set must stay an add
            ctrl_next.alu_op_0_sel = s1_data_i.bit30 & |s1_data_i.funct3;
            ctrl_next.alu_op_1_sel = s1_data_i.funct3;
        end
        rv_isa_pkg::CLASS_LUI: begin
            ctrl_next.alu_a_sel = rv_ctrl_pkg::ALU_A_ZERO;
        end
        rv_isa_pkg::CLASS_AUIPC: begin
            ctrl_next.alu_a_sel = rv_ctrl_pkg::ALU_A_PC;
        end
        rv_isa_pkg::CLASS_OP: begin
            ctrl_next.alu_b_sel    = rv_ctrl_pkg::ALU_B_RS2;
            ctrl_next.alu_op_0_sel = s1_data_i.bit30;
            ctrl_next.alu_op_1_sel = s1_data_i.funct3;
        end
        rv_isa_pkg::CLASS_JAL: begin
            ctrl_next.pc_wr_sel = rv_ctrl_pkg::PC_WR_ALU;
            ctrl_next.rd_wr_sel = rv_ctrl_pkg::RD_WR_PC_INC_4;
            ctrl_next.alu_a_sel = rv_ctrl_pkg::ALU_A_PC;
        end
        rv_isa_pkg::CLASS_JALR: begin
            ctrl_next.pc_wr_sel = rv_ctrl_pkg::PC_WR_JALR;
            ctrl_next.rd_wr_sel = rv_ctrl_pkg::RD_WR_PC_INC_4;
        end
        rv_isa_pkg::CLASS_BRANCH: begin
            ctrl_next.pc_wr_sel = rv_ctrl_pkg::PC_WR_COND;
            ctrl_next.rd_wr_en  = 1'b0;
            ctrl_next.alu_a_sel = rv_ctrl_pkg::ALU_A_PC;
        end
        rv_isa_pkg::CLASS_LOAD: begin
            ctrl_next.pc_wr_en  = 1'b0;    // PC waits for the load data
            ctrl_next.rd_wr_sel = rv_ctrl_pkg::RD_WR_DRAM;
        end
        rv_isa_pkg::CLASS_STORE: begin
            ctrl_next.rd_wr_en   = 1'b0;
            ctrl_next.dram_wr_en = 1'b1;
        end
        default: begin
            ctrl_next.rd_wr_en  = 1'b0;
            ctrl_next.alu_a_sel = rv_ctrl_pkg::ALU_A_ZERO;
            ctrl_next.alu_b_sel = rv_ctrl_pkg::ALU_B_ZERO;
        end
    endcase

    ctrl_next.rd_wr_addr   = s1_data_i.rd;
    ctrl_next.rs1_rd_addr  = s1_data_i.rs1;
    ctrl_next.rs2_rd_addr  = s1_data_i.rs2;
    ctrl_next.alu_comp_sel = s1_data_i.funct3;
    ctrl_next.dram_wr_sel  = s1_data_i.funct3;
    ctrl_next.dram_rd_sel  = s1_data_i.funct3;
    ctrl_next.imm          = s1_data_i.imm;
end

pipe_stage_reg #(
    .payload_t (rv_ctrl_pkg::ctrl_word_t)
) u_stage_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s1_valid_i),
    .ready_o (s1_ready_o),
    .data_i  (ctrl_next),
    .valid_o (dec_valid_o),
    .ready_i (dec_ready_i),
    .data_o  (ctrl_q)
);

assign pc_wr_en_o     = ctrl_q.pc_wr_en;
assign pc_wr_sel_o    = ctrl_q.pc_wr_sel;
assign rd_wr_en_o     = ctrl_q.rd_wr_en;
assign rd_wr_sel_o    = ctrl_q.rd_wr_sel;
assign rd_wr_addr_o   = ctrl_q.rd_wr_addr;
assign rs1_rd_addr_o  = ctrl_q.rs1_rd_addr;
assign rs2_rd_addr_o  = ctrl_q.rs2_rd_addr;
assign alu_a_sel_o    = ctrl_q.alu_a_sel;
assign alu_b_sel_o    = ctrl_q.alu_b_sel;
assign alu_comp_sel_o = ctrl_q.alu_comp_sel;
assign alu_op_0_sel_o = ctrl_q.alu_op_0_sel;
assign alu_op_1_sel_o = ctrl_q.alu_op_1_sel;
assign dram_wr_en_o   = ctrl_q.dram_wr_en;
assign dram_wr_sel_o  = ctrl_q.dram_wr_sel;
assign dram_rd_sel_o  = ctrl_q.dram_rd_sel;
assign imm_rd_data_o  = ctrl_q.imm;

// A store never writes back, whatever class stage 1 produced
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_o |-> !(dram_wr_en_o && rd_wr_en_o))
    else $error("ctrl_decode_stage: memory write and register write both set");

endmodule

// File: src/imm_gen_stage.sv
/* Stage 1: opcode classification, register field extraction and
   immediate generation, followed by the stage register */

module imm_gen_stage (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic                            inst_valid_i,
    output logic                            inst_ready_o,
    input  logic [rv_isa_pkg::XLEN-1:0]     inst_data_i,

    output logic                            s1_valid_o,
    input  logic                            s1_ready_i,
    output rv_ctrl_pkg::imm_stage_t         s1_data_o
);

logic [4:0] opcode_g;

logic [11:0] imm_i;
logic [11:0] imm_s;
logic [11:0] imm_b;
logic [19:0] imm_u;
logic [19:0] imm_j;

rv_isa_pkg::opcode_class_e op_class;
rv_ctrl_pkg::imm_stage_t   s1_next;

assign opcode_g = inst_data_i[6:2];

assign imm_i = inst_data_i[31:20];
assign imm_s = {inst_data_i[31:25], inst_data_i[11:7]};
assign imm_b = {inst_data_i[31], inst_data_i[7], inst_data_i[30:25], inst_data_i[11:8]};
assign imm_u = inst_data_i[31:12];
assign imm_j = {inst_data_i[31], inst_data_i[19:12], inst_data_i[20], inst_data_i[30:21]};

always_comb begin
    op_class = rv_isa_pkg::CLASS_NONE;

    // Words without both low bits set are not 32-bit instructions
    if (&inst_data_i[1:0]) begin
        case (opcode_g)
            rv_isa_pkg::OPCODE_G_OP_IMM: op_class = rv_isa_pkg::CLASS_OP_IMM;
            rv_isa_pkg::OPCODE_G_LUI:    op_class = rv_isa_pkg::CLASS_LUI;
            rv_isa_pkg::OPCODE_G_AUIPC:  op_class = rv_isa_pkg::CLASS_AUIPC;
            rv_isa_pkg::OPCODE_G_OP:     op_class = rv_isa_pkg::CLASS_OP;
            rv_isa_pkg::OPCODE_G_JAL:    op_class = rv_isa_pkg::CLASS_JAL;
            rv_isa_pkg::OPCODE_G_JALR:   op_class = rv_isa_pkg::CLASS_JALR;
            rv_isa_pkg::OPCODE_G_BRANCH: op_class = rv_isa_pkg::CLASS_BRANCH;
            rv_isa_pkg::OPCODE_G_LOAD:   op_class = rv_isa_pkg::CLASS_LOAD;
            rv_isa_pkg::OPCODE_G_STORE:  op_class = rv_isa_pkg::CLASS_STORE;
            default:                     op_class = rv_isa_pkg::CLASS_NONE;
        endcase
    end
end

always_comb begin
    s1_next.op_class = op_class;
    s1_next.rd       = inst_data_i[11:7];
    s1_next.rs1      = inst_data_i[19:15];
    s1_next.rs2      = inst_data_i[24:20];
    s1_next.funct3   = inst_data_i[14:12];
    s1_next.bit30    = inst_data_i[30];    // Selects SUB and SRA in stage 2

    case (op_class)
        rv_isa_pkg::CLASS_OP_IMM,
        rv_isa_pkg::CLASS_JALR,
        rv_isa_pkg::CLASS_LOAD:   s1_next.imm = {{20{imm_i[11]}}, imm_i};
        rv_isa_pkg::CLASS_STORE:  s1_next.imm = {{20{imm_s[11]}}, imm_s};
        rv_isa_pkg::CLASS_BRANCH: s1_next.imm = {{19{imm_b[11]}}, imm_b, 1'b0};
        rv_isa_pkg::CLASS_LUI,
        rv_isa_pkg::CLASS_AUIPC:  s1_next.imm = {imm_u, 12'h000};
        rv_isa_pkg::CLASS_JAL:    s1_next.imm = {{11{imm_j[19]}}, imm_j, 1'b0};
        default:                  s1_next.imm = '0;
    endcase
end

pipe_stage_reg #(
    .payload_t (rv_ctrl_pkg::imm_stage_t)
) u_stage_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (inst_valid_i),
    .ready_o (inst_ready_o),
    .data_i  (s1_next),
    .valid_o (s1_valid_o),
    .ready_i (s1_ready_i),
    .data_o  (s1_data_o)
);

endmodule

// File: src/pipe_stage_reg.sv
/* One-entry valid/ready pipeline register for any packed payload type */

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

logic     valid_q;
payload_t data_q;

// Empty slot, or the held word leaves on this same edge
assign ready_o = ~valid_q | ready_i;

assign valid_o = valid_q;
assign data_o  = data_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        valid_q <= 1'b0;
        data_q  <= '0;    // Cleared word reads as no operation downstream
    end else begin
        if (ready_o) begin
            valid_q <= valid_i;
        end

        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end
end

// ----------------------------------------------------------------------------
// A stalled word must stay put until the consumer takes it
// ----------------------------------------------------------------------------
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("pipe_stage_reg: held word dropped or changed under stall");

endmodule

// File: src/rv_ctrl_pkg.sv
/* Control-select encodings, default ALU operation codes and the
   payload structs carried by the two decode stages */

package rv_ctrl_pkg;

    localparam int unsigned FUNCT3_W = 3;

    // ------------------------------------------------------------------------
    // Select encodings
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        PC_WR_NEXT = 2'd0,
        PC_WR_ALU  = 2'd1,
        PC_WR_JALR = 2'd2,
        PC_WR_COND = 2'd3    // Taken or not is resolved in execute
    } pc_wr_sel_e;

    typedef enum logic [1:0] {
        RD_WR_ALU      = 2'd0,
        RD_WR_DRAM     = 2'd1,
        RD_WR_PC_INC_4 = 2'd2
    } rd_wr_sel_e;

    typedef enum logic [1:0] {
        ALU_A_ZERO = 2'd0,
        ALU_A_RS1  = 2'd1,
        ALU_A_PC   = 2'd2
    } alu_a_sel_e;

    typedef enum logic [1:0] {
        ALU_B_ZERO = 2'd0,
        ALU_B_RS2  = 2'd1,
        ALU_B_IMM  = 2'd2
    } alu_b_sel_e;

    localparam logic                ALU_OP_0_ADD_SRL = 1'b0;
    localparam logic [FUNCT3_W-1:0] ALU_OP_1_ADD     = 3'b000;

    // ------------------------------------------------------------------------
    // Stage payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        rv_isa_pkg::opcode_class_e               op_class;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]       rd;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]       rs1;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]       rs2;
        logic [FUNCT3_W-1:0]                     funct3;
        logic                                    bit30;
        logic [rv_isa_pkg::XLEN-1:0]             imm;
    } imm_stage_t;

    typedef struct packed {
        logic                                    pc_wr_en;
        pc_wr_sel_e                              pc_wr_sel;
        logic                                    rd_wr_en;
        rd_wr_sel_e                              rd_wr_sel;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]       rd_wr_addr;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]       rs1_rd_addr;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]       rs2_rd_addr;
        alu_a_sel_e                              alu_a_sel;
        alu_b_sel_e                              alu_b_sel;
        logic [FUNCT3_W-1:0]                     alu_comp_sel;
        logic                                    alu_op_0_sel;
        logic [FUNCT3_W-1:0]                     alu_op_1_sel;
        logic                                    dram_wr_en;
        logic [FUNCT3_W-1:0]                     dram_wr_sel;
        logic [FUNCT3_W-1:0]                     dram_rd_sel;
        logic [rv_isa_pkg::XLEN-1:0]             imm;
    } ctrl_word_t;

endpackage

// File: src/rv_isa_pkg.sv
/* RV32I instruction-set constants, opcode-group codes from bits 6 to 2
   and the opcode-class enum used between the decode stages */

package rv_isa_pkg;

    // ------------------------------------------------------------------------
    // Word and field widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    // ------------------------------------------------------------------------
    // Opcode groups, instruction bits 6 to 2
    // ------------------------------------------------------------------------
    localparam logic [4:0] OPCODE_G_LOAD   = 5'b00000;
    localparam logic [4:0] OPCODE_G_OP_IMM = 5'b00100;
    localparam logic [4:0] OPCODE_G_AUIPC  = 5'b00101;
    localparam logic [4:0] OPCODE_G_STORE  = 5'b01000;
    localparam logic [4:0] OPCODE_G_OP     = 5'b01100;
    localparam logic [4:0] OPCODE_G_LUI    = 5'b01101;
    localparam logic [4:0] OPCODE_G_BRANCH = 5'b11000;
    localparam logic [4:0] OPCODE_G_JALR   = 5'b11001;
    localparam logic [4:0] OPCODE_G_JAL    = 5'b11011;

    // CLASS_NONE is zero so a cleared stage register reads as no operation
    typedef enum logic [3:0] {
        CLASS_NONE   = 4'd0,
        CLASS_OP_IMM = 4'd1,
        CLASS_LUI    = 4'd2,
        CLASS_AUIPC  = 4'd3,
        CLASS_OP     = 4'd4,
        CLASS_JAL    = 4'd5,
        CLASS_JALR   = 4'd6,
        CLASS_BRANCH = 4'd7,
        CLASS_LOAD   = 4'd8,
        CLASS_STORE  = 4'd9
    } opcode_class_e;

endpackage
